//--- project.f
rtl/clkCfgPkg.sv
rtl/axiLitePkg.sv
rtl/pllRegBank.sv
rtl/pllLockDetect.sv
rtl/pllPostScaler.sv
rtl/pllClockGen.sv
bench/benchClock.sv
bench/pllClockGenTb.sv

//--- bench/pll_testdata.txt
# op target data expect, all hex. W: addr wdata bresp. R: addr rdata rresp
# L: addr wdata cycles-to-lock. M: channel unused period-ns, 0 means held low
M 0 0 0
M 1 0 0
R 10 1 0
W 4 103 0
R 4 103 0
W 8 205 0
R 8 205 0
W 0 5 0
R 0 5 0
M 0 0 60
M 1 0 140
W 10 1 2
R 14 0 2
W 20 0 2
L c 5 6
R c 5 0
L 4 0 6
M 0 0 10
L 4 1 6
M 0 0 10
L c 0 2
R 10 1 0
W 8 302 0
M 1 0 100
W 0 7 0
M 0 0 14
W 0 4 0
M 0 0 0
M 1 0 100
W 4 7f 0
W 8 1a 0
W c 33 0
R 4 7f 0
R 8 1a 0
R c 33 0

//--- bench/pllClockGenTb.sv
// PLL clock generator testbench
// Replays testdata operations over AXI4-Lite, checks responses, lock timing and periods

`timescale 1ns/100ps

module pllClockGenTb;

  localparam int CkPeriodNs = 8;

  logic                CK_XTAL_IN;
  logic                CK_AUX_IN;
  logic                RST_N;
  axiLitePkg::axiReq_t axiReq;
  axiLitePkg::axiRsp_t axiRsp;
  logic                LOCKED;
  logic                CK_PLL_OUT0;
  logic                CK_PLL_OUT1;

  logic [7:0]  opQ[$];    // Operation code per line
  logic [31:0] tgtQ[$];   // Address or channel
  logic [31:0] datQ[$];
  logic [31:0] expQ[$];   // Response, cycle count or period in ns
  integer      seed;
  int          passCnt;
  int          failCnt;
  logic        testOk;    // Cleared by any failing check of the current test
  time         timeoutNs;

  benchClock clkGen (.CK_XTAL_IN(CK_XTAL_IN), .CK_AUX_IN(CK_AUX_IN), .RST_N(RST_N));

  pllClockGen #(.AddrW(5), .LockCntW(12)) uut (
    .CK_XTAL_IN  (CK_XTAL_IN),
    .CK_AUX_IN   (CK_AUX_IN),
    .RST_N       (RST_N),
    .axiReq      (axiReq),
    .axiRsp      (axiRsp),
    .LOCKED      (LOCKED),
    .CK_PLL_OUT0 (CK_PLL_OUT0),
    .CK_PLL_OUT1 (CK_PLL_OUT1)
  );

  // --------------------------------------------------
  // Testdata and reporting
  // --------------------------------------------------
  task automatic loadTestdata(output bit ok);
    integer           fd;
    integer           n;
    logic [63:0]      opWord;
    logic [8*160-1:0] rest;
    logic [31:0]      tgt, dat, expVal;
    ok = 1'b0;
    fd = $fopen("bench/pll_testdata.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", opWord);
      if (n == 1 && opWord[7:0] == "#") begin
        n = $fgets(rest, fd);                 // Skip the comment text
      end else if (n == 1) begin
        n = $fscanf(fd, "%h %h %h", tgt, dat, expVal);
        opQ.push_back(opWord[7:0]);
        tgtQ.push_back(tgt);
        datQ.push_back(dat);
        expQ.push_back(expVal);
      end
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  task automatic reportTest(input string label);
    if (testOk) passCnt++;
    else failCnt++;
    $display("%s : %s", label, testOk ? "PASS" : "FAIL");
  endtask

  // --------------------------------------------------
  // AXI4-Lite master, entered 1 ns after a rising edge
  // --------------------------------------------------
  task automatic writeReg(input logic [31:0] addr, input logic [31:0] data,
                          input int stall, output logic [1:0] resp);
    axiReq.awvalid = 1'b1;
    axiReq.awaddr  = addr;
    axiReq.wvalid  = 1'b1;
    axiReq.wdata   = data;
    axiReq.wstrb   = 4'hF;
    do @(negedge CK_XTAL_IN); while (!axiRsp.awready);
    assert (axiRsp.wready) else begin     // W taken together with AW
      $display("[ERROR] wready: got 0x%h, expected 0x1", axiRsp.wready);
      testOk = 1'b0;
    end
    @(posedge CK_XTAL_IN);                  // AW and W taken here
    #1;
    axiReq.awvalid = 1'b0;
    axiReq.wvalid  = 1'b0;
    if (stall > 0) begin
      repeat (stall) @(posedge CK_XTAL_IN); // Hold off the response
      #1;
    end
    axiReq.bready = 1'b1;
    do @(negedge CK_XTAL_IN); while (!axiRsp.bvalid);
    resp = axiRsp.bresp;
    @(posedge CK_XTAL_IN);                  // B handshake
    #1;
    axiReq.bready = 1'b0;
  endtask

  task automatic readReg(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    axiReq.arvalid = 1'b1;
    axiReq.araddr  = addr;
    axiReq.rready  = 1'b1;
    do @(negedge CK_XTAL_IN); while (!axiRsp.arready);
    @(posedge CK_XTAL_IN);
    #1;
    axiReq.arvalid = 1'b0;
    do @(negedge CK_XTAL_IN); while (!axiRsp.rvalid);
    data = axiRsp.rdata;
    resp = axiRsp.rresp;
    @(posedge CK_XTAL_IN);                  // R handshake
    #1;
    axiReq.rready = 1'b0;
  endtask

  // --------------------------------------------------
  // Output clock observation
  // --------------------------------------------------
  task automatic waitRise(input logic ch);
    if (ch) @(posedge CK_PLL_OUT1);
    else @(posedge CK_PLL_OUT0);
  endtask

  task automatic measurePeriod(input logic ch, output time period);
    time t0;
    repeat (3) waitRise(ch);                // First edge, then two periods skipped
    t0 = $time;
    waitRise(ch);
    period = $time - t0;
  endtask

  task automatic holdLow(input logic ch);
    bit sawHigh;
    sawHigh = 1'b0;
    repeat (100) begin
      @(negedge CK_XTAL_IN);
      if (ch ? CK_PLL_OUT1 : CK_PLL_OUT0) sawHigh = 1'b1;
    end
    assert (!sawHigh) else begin
      $display("[ERROR] CK_PLL_OUT%0d: got 0x1, expected 0x0", ch);
      testOk = 1'b0;
    end
  endtask

  // --------------------------------------------------
  // One testdata line
  // --------------------------------------------------
  task automatic runOp(input int idx);
    logic [7:0]  op;
    logic [31:0] tgt, dat, expVal;
    logic [31:0] rdVal;
    logic [1:0]  resp;
    int          cycles;
    time         period;
    op     = opQ[idx];
    tgt    = tgtQ[idx];
    dat    = datQ[idx];
    expVal = expQ[idx];
    testOk = 1'b1;
    case (op)
      "W": begin
        writeReg(tgt, dat, $unsigned($random(seed)) % 4, resp);
        assert (resp == expVal[1:0]) else begin
          $display("[ERROR] bresp: got 0x%h, expected 0x%h", resp, expVal[1:0]);
          testOk = 1'b0;
        end
      end
      "R": begin
        readReg(tgt, rdVal, resp);
        assert (rdVal == dat) else begin
          $display("[ERROR] rdata: got 0x%h, expected 0x%h", rdVal, dat);
          testOk = 1'b0;
        end
        assert (resp == expVal[1:0]) else begin
          $display("[ERROR] rresp: got 0x%h, expected 0x%h", resp, expVal[1:0]);
          testOk = 1'b0;
        end
      end
      "L": begin
        writeReg(tgt, dat, 0, resp);        // Count starts at the B edge
        assert (!LOCKED) else begin
          $display("LOCKED did not drop after the configuration write");
          testOk = 1'b0;
        end
        cycles = 0;
        while (!LOCKED && cycles <= expVal + 20) begin
          @(posedge CK_XTAL_IN);
          #1;
          cycles++;
        end
        assert (cycles == expVal) else begin
          $display("[ERROR] LOCKED rise cycle: got 0x%h, expected 0x%h", cycles, expVal);
          testOk = 1'b0;
        end
      end
      "M": begin
        if (expVal == 0) begin
          holdLow(tgt[0]);
        end else begin
          measurePeriod(tgt[0], period);
          assert (period == expVal) else begin
            $display("[ERROR] CK_PLL_OUT%0d period: got 0x%h, expected 0x%h",
                     tgt[0], period, expVal);
            testOk = 1'b0;
          end
        end
      end
      default: begin
        $display("Unknown operation code on testdata line %0d", idx);
        testOk = 1'b0;
      end
    endcase
    @(posedge CK_XTAL_IN);                  // Realign for the next drive
    #1;
    reportTest($sformatf("Op %0d %c %h %h %h", idx, op, tgt, dat, expVal));
  endtask

  // --------------------------------------------------
  // Watchdog, armed once the testdata is loaded
  // --------------------------------------------------
  initial begin : watchdog
    wait (timeoutNs != 0);
    #(timeoutNs);
    $display("Timeout: the run did not finish within %0d ns", timeoutNs);
    $display("Test failures found");
    $finish;
  end

  initial begin : mainFlow
    bit  loaded;
    time budget;
    seed      = 79;
    passCnt   = 0;
    failCnt   = 0;
    timeoutNs = 0;
    axiReq    = '0;
    loadTestdata(loaded);
    if (!loaded) begin
      $display("Could not open the testdata file bench/pll_testdata.txt");
      failCnt++;
    end else begin
      budget = 20 * CkPeriodNs;             // Reset phase
      foreach (opQ[k]) begin
        if (opQ[k] == "M") budget += 4 * expQ[k];
        budget += 200 * CkPeriodNs;
      end
      timeoutNs = budget;

      // Reset state
      testOk = 1'b1;
      @(negedge CK_XTAL_IN);
      assert (!LOCKED && !CK_PLL_OUT0 && !CK_PLL_OUT1) else begin
        $display("LOCKED or an output clock is high during reset");
        testOk = 1'b0;
      end
      assert (!axiRsp.bvalid && !axiRsp.rvalid && !axiRsp.awready) else begin
        $display("AXI response or ready is active during reset");
        testOk = 1'b0;
      end
      reportTest("Reset state");
      wait (RST_N);
      @(posedge CK_XTAL_IN);
      #1;

      for (int i = 0; i < opQ.size(); i++) runOp(i);
    end

    $display("Summary: %0d tests passed, %0d tests failed", passCnt, failCnt);
    if (failCnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- bench/benchClock.sv
// Bench clock and reset source
// Reference clock at 8 ns, unrelated aux clock at 20 ns, reset low for 10 cycles

`timescale 1ns/100ps

module benchClock (
  output logic CK_XTAL_IN,
  output logic CK_AUX_IN,
  output logic RST_N
);

  localparam real XtalHalfNs = 4.0;  // 8 ns period
  localparam real AuxHalfNs  = 10.0; // 20 ns period

  initial begin
    CK_XTAL_IN = 1'b0;
    forever #(XtalHalfNs) CK_XTAL_IN = ~CK_XTAL_IN;
  end

  initial begin
    CK_AUX_IN = 1'b0;
    #3;                                   // Offset from the reference
    forever #(AuxHalfNs) CK_AUX_IN = ~CK_AUX_IN;
  end

  initial begin
    RST_N = 1'b0;
    repeat (10) @(posedge CK_XTAL_IN);
    #1;
    RST_N = 1'b1;                         // Release just after an edge
  end

endmodule

//--- rtl/pllClockGen.sv
// PLL clock generator top
// Register bank, lock detector and two post-scaler outputs off the reference clock

`timescale 1ns/100ps

module pllClockGen #(
  parameter int AddrW    = 5,  // Register address bits
  parameter int LockCntW = 12  // Lock counter width
) (
  input  logic                CK_XTAL_IN,  // Reference clock
  input  logic                CK_AUX_IN,   // Bypass clock
  input  logic                RST_N,
  input  axiLitePkg::axiReq_t axiReq,
  output axiLitePkg::axiRsp_t axiRsp,
  output logic                LOCKED,
  output logic                CK_PLL_OUT0,
  output logic                CK_PLL_OUT1
);

  clkCfgPkg::postScaleCfg_t ps0Cfg;   // Channel 0 setting
  clkCfgPkg::postScaleCfg_t ps1Cfg;   // Channel 1 setting
  clkCfgPkg::lockCfg_t      lockCfg;
  logic                     cfgWrite; // Restarts the lock timer

  // --------------------------------------------------
  // Configuration and lock
  // --------------------------------------------------
  pllRegBank #(.AddrW(AddrW)) regBank (
    .CK_XTAL_IN (CK_XTAL_IN),
    .RST_N      (RST_N),
    .axiReq     (axiReq),
    .axiRsp     (axiRsp),
    .locked     (LOCKED),   // Shown in REG_STATUS
    .ps0Cfg     (ps0Cfg),
    .ps1Cfg     (ps1Cfg),
    .lockCfg    (lockCfg),
    .cfgWrite   (cfgWrite)
  );

  pllLockDetect #(.LockCntW(LockCntW)) lockDetect (
    .CK_XTAL_IN (CK_XTAL_IN),
    .RST_N      (RST_N),
    .lockCfg    (lockCfg),
    .cfgWrite   (cfgWrite),
    .locked     (LOCKED)
  );

  // --------------------------------------------------
  // Output channels
  // --------------------------------------------------
  pllPostScaler ps0Scaler (
    .CK_XTAL_IN (CK_XTAL_IN),
    .CK_AUX_IN  (CK_AUX_IN),
    .RST_N      (RST_N),
    .cfg        (ps0Cfg),
    .ckOut      (CK_PLL_OUT0)
  );

  pllPostScaler ps1Scaler (
    .CK_XTAL_IN (CK_XTAL_IN),
    .CK_AUX_IN  (CK_AUX_IN),
    .RST_N      (RST_N),
    .cfg        (ps1Cfg),
    .ckOut      (CK_PLL_OUT1)
  );

endmodule

//--- rtl/pllPostScaler.sv
// PLL post-scaler channel
// L1 power-of-two prescale, L2 toggle divider, enable gating and aux-clock bypass

`timescale 1ns/100ps

module pllPostScaler (
  input  logic                     CK_XTAL_IN, // Stands in for the VCO
  input  logic                     CK_AUX_IN,  // Bypass source
  input  logic                     RST_N,
  input  clkCfgPkg::postScaleCfg_t cfg,
  output logic                     ckOut
);

  logic [2:0] preCnt;   // L1 prescale counter
  logic [2:0] preMask;  // 2^l1 - 1
  logic       preTick;  // One reference cycle every 2^l1
  logic [1:0] actL1;    // Divider values in use
  logic [7:0] actL2;
  logic [7:0] l2Eff;    // l2 with 0 read as 1
  logic [7:0] l2Cnt;
  logic       l2Wrap;   // End of a half period
  logic       clkInt;   // Divided clock

  // --------------------------------------------------
  // Divider chain
  // --------------------------------------------------
  assign preMask = 3'((4'd1 << actL1) - 4'd1);
  assign preTick = (preCnt & preMask) == preMask;
  assign l2Eff   = (actL2 == 8'd0) ? 8'd1 : actL2;
  assign l2Wrap  = preTick && (l2Cnt >= l2Eff - 8'd1); // Also catches a shrunk l2

  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      preCnt <= 3'd0;
      l2Cnt  <= 8'd0;
      clkInt <= 1'b0;
      actL1  <= 2'd0;
      actL2  <= 8'd0;
    end else if (!cfg.enable) begin
      preCnt <= 3'd0;        // Restart cleanly on enable
      l2Cnt  <= 8'd0;
      actL1  <= cfg.l1;      // Track settings while idle
      actL2  <= cfg.l2;
    end else begin
      preCnt <= preCnt + 3'd1;
      if (l2Wrap) begin
        l2Cnt  <= 8'd0;
        clkInt <= ~clkInt;
        actL1  <= cfg.l1;    // New dividers only at a wrap
        actL2  <= cfg.l2;
      end else if (preTick) begin
        l2Cnt  <= l2Cnt + 8'd1;
      end
    end
  end

  // --------------------------------------------------
  // Output select
  // --------------------------------------------------
  assign ckOut = cfg.bypass ? CK_AUX_IN : (cfg.enable & clkInt); // Off means low

  // Divided clock is frozen while the channel is off
  assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    !cfg.enable |=> $stable(clkInt))
    else $error("divided clock moved while disabled");

endmodule

//--- rtl/pllLockDetect.sv
// PLL lock detector
// Drops lock on every configuration write and reasserts it after a programmed delay

`timescale 1ns/100ps

module pllLockDetect #(
  parameter int LockCntW = 12 // Counter width, up to 16
) (
  input  logic                CK_XTAL_IN,
  input  logic                RST_N,
  input  clkCfgPkg::lockCfg_t lockCfg,
  input  logic                cfgWrite, // Restart strobe
  output logic                locked
);

  logic [LockCntW-1:0] lockCnt;  // Cycles left before lock
  logic [LockCntW-1:0] loadVal;

  // A zero count still waits one cycle, so lock comes two cycles later
  assign loadVal = (lockCfg.lockCount[LockCntW-1:0] == '0) ? LockCntW'(1)
                                                            : lockCfg.lockCount[LockCntW-1:0];

  // --------------------------------------------------
  // Down-counter
  // --------------------------------------------------
  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      lockCnt <= LockCntW'(1); // Reset release counts as a write of zero
      locked  <= 1'b0;
    end else if (cfgWrite) begin
      lockCnt <= loadVal;      // Restart on any new setting
      locked  <= 1'b0;
    end else if (lockCnt != '0) begin
      lockCnt <= lockCnt - LockCntW'(1);
    end else begin
      locked  <= 1'b1;         // Expired
    end
  end

  // Lock only rises from an idle counter with no restart pending
  assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    $rose(locked) |-> $past(lockCnt) == '0 && !$past(cfgWrite))
    else $error("lock rose while counting");

  // A configuration write always clears lock on the next edge
  assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    cfgWrite |=> !locked)
    else $error("lock held across a config write");

endmodule

//--- rtl/pllRegBank.sv
// PLL register bank
// AXI4-Lite slave for the post-scaler and lock settings, with live lock status

`timescale 1ns/100ps

module pllRegBank #(
  parameter int AddrW = 5 // Decoded address bits
) (
  input  logic                     CK_XTAL_IN,
  input  logic                     RST_N,
  input  axiLitePkg::axiReq_t      axiReq,
  output axiLitePkg::axiRsp_t      axiRsp,
  input  logic                     locked,   // Live lock status
  output clkCfgPkg::postScaleCfg_t ps0Cfg,
  output clkCfgPkg::postScaleCfg_t ps1Cfg,
  output clkCfgPkg::lockCfg_t      lockCfg,
  output logic                     cfgWrite  // One cycle after a good write
);

  typedef enum logic [2:0] {
    SEL_CTRL, SEL_DIV0, SEL_DIV1, SEL_LOCK, SEL_STATUS, SEL_NONE
  } regSel_t;

  logic        bValid;
  logic        rValid;
  logic [1:0]  bResp;
  logic [1:0]  rResp;
  logic [31:0] rData;
  logic        wrAccept;  // AW and W taken together
  logic        rdAccept;
  logic        wrOk;      // Target is writable
  regSel_t     wrSel;
  regSel_t     rdSel;
  logic [31:0] wrMerged;  // Current word with strobed bytes replaced

  // --------------------------------------------------
  // Address decode and register view
  // --------------------------------------------------
  function automatic regSel_t decodeAddr(input logic [31:0] addr);
    regSel_t sel;
    sel = SEL_NONE;
    if ((addr >> AddrW) == 32'd0) begin // Nothing above the decoded bits
      case (addr[AddrW-1:0])
        AddrW'(clkCfgPkg::REG_CTRL):   sel = SEL_CTRL;
        AddrW'(clkCfgPkg::REG_DIV0):   sel = SEL_DIV0;
        AddrW'(clkCfgPkg::REG_DIV1):   sel = SEL_DIV1;
        AddrW'(clkCfgPkg::REG_LOCK):   sel = SEL_LOCK;
        AddrW'(clkCfgPkg::REG_STATUS): sel = SEL_STATUS;
        default:                       sel = SEL_NONE;
      endcase
    end
    return sel;
  endfunction

  function automatic logic [31:0] divWord(input clkCfgPkg::postScaleCfg_t cfg);
    logic [31:0] word;
    word = 32'd0;
    word[clkCfgPkg::DIV_L2_LSB +: 8] = cfg.l2;
    word[clkCfgPkg::DIV_L1_LSB +: 2] = cfg.l1;
    return word;
  endfunction

  function automatic logic [31:0] regWord(input regSel_t sel);
    logic [31:0] word;
    word = 32'd0;
    case (sel)
      SEL_CTRL: begin
        word[clkCfgPkg::CTRL_PS0_EN]  = ps0Cfg.enable;
        word[clkCfgPkg::CTRL_PS0_BYP] = ps0Cfg.bypass;
        word[clkCfgPkg::CTRL_PS1_EN]  = ps1Cfg.enable;
        word[clkCfgPkg::CTRL_PS1_BYP] = ps1Cfg.bypass;
      end
      SEL_DIV0:   word = divWord(ps0Cfg);
      SEL_DIV1:   word = divWord(ps1Cfg);
      SEL_LOCK:   word[15:0] = lockCfg.lockCount;
      SEL_STATUS: word[0] = locked;
      default:    word = 32'd0;
    endcase
    return word;
  endfunction

  assign wrSel    = decodeAddr(axiReq.awaddr);
  assign rdSel    = decodeAddr(axiReq.araddr);
  assign wrOk     = (wrSel != SEL_NONE) && (wrSel != SEL_STATUS);
  assign wrAccept = axiReq.awvalid && axiReq.wvalid && !bValid && !rValid;
  assign rdAccept = axiReq.arvalid && !bValid && !rValid && !wrAccept; // Write wins a tie

  always_comb begin
    wrMerged = regWord(wrSel);
    for (int i = 0; i < 4; i++) begin
      if (axiReq.wstrb[i]) wrMerged[8*i +: 8] = axiReq.wdata[8*i +: 8];
    end
  end

  // --------------------------------------------------
  // Control state and configuration registers
  // --------------------------------------------------
  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      bValid   <= 1'b0;
      rValid   <= 1'b0;
      cfgWrite <= 1'b0;
      ps0Cfg   <= '0;  // Both channels off
      ps1Cfg   <= '0;
      lockCfg  <= '0;
    end else begin
      cfgWrite <= wrAccept && wrOk; // Lands in the cycle after the handshake
      if (wrAccept) begin
        bValid <= 1'b1;
        case (wrSel)
          SEL_CTRL: begin
            ps0Cfg.enable <= wrMerged[clkCfgPkg::CTRL_PS0_EN];
            ps0Cfg.bypass <= wrMerged[clkCfgPkg::CTRL_PS0_BYP];
            ps1Cfg.enable <= wrMerged[clkCfgPkg::CTRL_PS1_EN];
            ps1Cfg.bypass <= wrMerged[clkCfgPkg::CTRL_PS1_BYP];
          end
          SEL_DIV0: begin
            ps0Cfg.l2 <= wrMerged[clkCfgPkg::DIV_L2_LSB +: 8];
            ps0Cfg.l1 <= wrMerged[clkCfgPkg::DIV_L1_LSB +: 2];
          end
          SEL_DIV1: begin
            ps1Cfg.l2 <= wrMerged[clkCfgPkg::DIV_L2_LSB +: 8];
            ps1Cfg.l1 <= wrMerged[clkCfgPkg::DIV_L1_LSB +: 2];
          end
          SEL_LOCK: lockCfg.lockCount <= wrMerged[15:0];
          default: ; // Status and holes are not written
        endcase
      end else if (bValid && axiReq.bready) begin
        bValid <= 1'b0;
      end
      if (rdAccept) begin
        rValid <= 1'b1;
      end else if (rValid && axiReq.rready) begin
        rValid <= 1'b0;
      end
    end
  end

  // Response payload, only meaningful under bvalid or rvalid
  always_ff @(posedge CK_XTAL_IN) begin
    if (wrAccept) bResp <= wrOk ? axiLitePkg::RESP_OKAY : axiLitePkg::RESP_SLVERR;
    if (rdAccept) begin
      rData <= regWord(rdSel); // Holes read as zero
      rResp <= (rdSel == SEL_NONE) ? axiLitePkg::RESP_SLVERR : axiLitePkg::RESP_OKAY;
    end
  end

  assign axiRsp.awready = wrAccept;
  assign axiRsp.wready  = wrAccept;
  assign axiRsp.bvalid  = bValid;
  assign axiRsp.bresp   = bResp;
  assign axiRsp.arready = rdAccept;
  assign axiRsp.rvalid  = rValid;
  assign axiRsp.rdata   = rData;
  assign axiRsp.rresp   = rResp;

  // Accepted write is answered next edge on B alone
  assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    axiRsp.awready |=> axiRsp.bvalid && !axiRsp.rvalid)
    else $error("write accept not answered alone on B");

  // Accepted read is answered next edge on R alone
  assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    axiRsp.arready |=> axiRsp.rvalid && !axiRsp.bvalid)
    else $error("read accept not answered alone on R");

  // A stalled write response keeps its code
  assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid && $stable(axiRsp.bresp))
    else $error("bresp changed under stall");

endmodule

//--- rtl/axiLitePkg.sv
// AXI4-Lite package
// Channel structs and response codes for the register port

package axiLitePkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // --------------------------------------------------
  // Master to slave
  // --------------------------------------------------
  typedef struct packed {
    logic              awvalid; // Write address valid
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;  // Write data valid
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;   // Byte enables
    logic              bready;
    logic              arvalid; // Read address valid
    logic [ADDR_W-1:0] araddr;
    logic              rready;
  } axiReq_t;

  // --------------------------------------------------
  // Slave to master
  // --------------------------------------------------
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;  // Write response valid
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;  // Read data valid
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } axiRsp_t;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- rtl/clkCfgPkg.sv
// Clock configuration package
// Post-scaler and lock settings plus the register map of the PLL clock block

package clkCfgPkg;

  // --------------------------------------------------
  // Per-channel post-scaler setting
  // --------------------------------------------------
  typedef struct packed {
    logic       enable; // Channel running
    logic       bypass; // Output follows CK_AUX_IN
    logic [1:0] l1;     // L1 exponent, divide by 1, 2, 4 or 8
    logic [7:0] l2;     // L2 half-period count, 0 acts as 1
  } postScaleCfg_t;

  // Lock detector setting
  typedef struct packed {
    logic [15:0] lockCount; // Reference cycles until lock
  } lockCfg_t;

  // --------------------------------------------------
  // Register offsets
  // --------------------------------------------------
  localparam logic [7:0] REG_CTRL   = 8'h00; // Enables and bypasses
  localparam logic [7:0] REG_DIV0   = 8'h04; // Channel 0 dividers
  localparam logic [7:0] REG_DIV1   = 8'h08; // Channel 1 dividers
  localparam logic [7:0] REG_LOCK   = 8'h0C; // Lock count
  localparam logic [7:0] REG_STATUS = 8'h10; // Read-only, bit 0 is LOCKED

  // Bit positions inside REG_CTRL
  localparam int CTRL_PS0_EN  = 0;
  localparam int CTRL_PS0_BYP = 1;
  localparam int CTRL_PS1_EN  = 2;
  localparam int CTRL_PS1_BYP = 3;

  // Field positions inside REG_DIV0 and REG_DIV1
  localparam int DIV_L2_LSB = 0; // Bits 7:0
  localparam int DIV_L1_LSB = 8; // Bits 9:8

endpackage
